// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_pet_io
FILELIST  ?= build.f
OBJDIR    ?= obj_dir

SIM_BIN   := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Status comes from the pass line in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf $(OBJDIR)

// File: build.f
verilog/pet_io_pkg.sv
verilog/io_address_decoder.sv
verilog/usb_kbd_matrix.sv
verilog/io_intercept.sv
verilog/pet_io_top.sv
dv/tb_pet_io.sv

// File: dv/tb_pet_io.sv
// Testbench for the PET keyboard injection block checking port B interception against a key model
`timescale 1ns/1ps

module tb_pet_io;

    logic                   wb_clock_i = 1'b0;
    logic                   rst_n_i;
    logic                   cpu_be_i;
    logic                   cpu_we_i;
    pet_io_pkg::addr_t      cpu_addr_i;
    pet_io_pkg::data_t      cpu_data_i;
    pet_io_pkg::data_t      cpu_data_o;
    logic                   cpu_data_oe_o;
    logic                   kbd_we_i;
    pet_io_pkg::kbd_event_t kbd_event_i;
    logic                   kbd_clear_i;

    // Reference model is active low like the key buffer
    logic [7:0]  model_mat [16];                    // Columns 10..15 stay all ones
    logic [3:0]  model_col;                         // Column last written to PIA1 port A

    int          pass_cnt       = 0;
    int          fail_cnt       = 0;
    int          mon_pass_cnt   = 0;                // Idle-cycle enable checks
    int          mon_fail_cnt   = 0;
    int          test_fail_base = 0;
    int unsigned rnd;
    logic        prev_read      = 1'b0;             // Read strobe seen at last rising edge

    pet_io_top u_dut (
        .wb_clock_i    (wb_clock_i),
        .rst_n_i       (rst_n_i),
        .cpu_be_i      (cpu_be_i),
        .cpu_we_i      (cpu_we_i),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_data_i    (cpu_data_i),
        .cpu_data_o    (cpu_data_o),
        .cpu_data_oe_o (cpu_data_oe_o),
        .kbd_we_i      (kbd_we_i),
        .kbd_event_i   (kbd_event_i),
        .kbd_clear_i   (kbd_clear_i)
    );

    always #10 wb_clock_i = ~wb_clock_i;            // 20 ns period

    always @(posedge wb_clock_i) begin
        prev_read <= cpu_be_i & ~cpu_we_i;
    end

    // Outside a read response the enable must stay low
    always @(negedge wb_clock_i) begin
        if (!prev_read) begin
            assert (cpu_data_oe_o == 1'b0) begin
                mon_pass_cnt++;
            end else begin
                mon_fail_cnt++;
                $display("MISMATCH cpu_data_oe_o: got 0x%h, expected 0x0 in a non-read cycle",
                         cpu_data_oe_o);
            end
        end
    end

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got == exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge wb_clock_i);
    endtask

    // One bus cycle starting and ending on a falling edge
    task automatic cpu_write(input pet_io_pkg::addr_t addr, input pet_io_pkg::data_t data);
        cpu_be_i   = 1'b1;
        cpu_we_i   = 1'b1;
        cpu_addr_i = addr;
        cpu_data_i = data;
        @(negedge wb_clock_i);
        cpu_be_i   = 1'b0;
        cpu_we_i   = 1'b0;
        // Page $E8 with A4 alone among A6..A4 hitting PIA register 0
        if (addr[15:8] == 8'hE8 && addr[6:4] == 3'b001 && addr[1:0] == 2'd0) begin
            model_col = data[3:0];
        end
    endtask

    task automatic cpu_read(input pet_io_pkg::addr_t addr, input logic chk_data,
                            input logic [7:0] exp_data, input logic exp_oe);
        cpu_be_i   = 1'b1;
        cpu_we_i   = 1'b0;
        cpu_addr_i = addr;
        @(negedge wb_clock_i);
        cpu_be_i   = 1'b0;
        // Response registered on the edge that took the strobe
        check_value("cpu_data_oe_o", {7'b0, cpu_data_oe_o}, {7'b0, exp_oe});
        if (chk_data) begin
            check_value("cpu_data_o", cpu_data_o, exp_data);
        end
    endtask

    // Expected byte from the model with the enable set when any key in the column is down
    task automatic read_port_b();
        cpu_read(16'hE812, 1'b1, model_mat[model_col], model_mat[model_col] != 8'hFF);
    endtask

    task automatic scan_col(input logic [3:0] col);
        cpu_write(16'hE810, {4'h0, col});
        idle(3);                                    // Lets the lookup pipeline settle
        read_port_b();
    endtask

    task automatic scan_all();
        for (int c = 0; c < 16; c++) begin
            scan_col(4'(c));
        end
    endtask

    task automatic key_event(input logic [3:0] col, input logic [2:0] row, input logic pressed);
        kbd_we_i            = 1'b1;
        kbd_event_i.col     = col;
        kbd_event_i.row     = row;
        kbd_event_i.pressed = pressed;
        @(negedge wb_clock_i);
        kbd_we_i            = 1'b0;
        if (int'(col) < pet_io_pkg::KBD_COL_COUNT) begin
            model_mat[col][row] = ~pressed;         // Events past column 9 are dropped
        end
    endtask

    task automatic clear_keys();
        kbd_clear_i = 1'b1;
        @(negedge wb_clock_i);
        kbd_clear_i = 1'b0;
        for (int c = 0; c < 16; c++) begin
            model_mat[c] = 8'hFF;
        end
    endtask

    task automatic load_random_keys();
        for (int c = 0; c < pet_io_pkg::KBD_COL_COUNT; c++) begin
            for (int r = 0; r < pet_io_pkg::KBD_ROW_COUNT; r++) begin
                rnd = $urandom();
                key_event(4'(c), 3'(r), rnd[1:0] == 2'b00);  // Roughly one key in four
            end
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = fail_cnt + mon_fail_cnt - test_fail_base;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errs);
        end
        test_fail_base = fail_cnt + mon_fail_cnt;
    endtask

    initial begin
        cpu_be_i    = 1'b0;
        cpu_we_i    = 1'b0;
        cpu_addr_i  = '0;
        cpu_data_i  = '0;
        kbd_we_i    = 1'b0;
        kbd_event_i = '0;
        kbd_clear_i = 1'b0;
        model_col   = 4'h0;                         // Latch reset value
        for (int c = 0; c < 16; c++) begin
            model_mat[c] = 8'hFF;
        end
        rnd = $urandom(32'h688f_0b8f);              // Seed once for the whole run

        rst_n_i = 1'b0;
        repeat (2) @(negedge wb_clock_i);
        rst_n_i = 1'b1;

        // Nothing to inject while quiet after reset
        idle(4);
        read_port_b();
        end_test("after_reset");

        key_event(4'd3, 3'd5, 1'b1);
        scan_col(4'd3);                             // Expect 0xDF with the enable
        scan_col(4'd4);
        end_test("single_key");

        for (int round = 0; round < 3; round++) begin
            clear_keys();
            load_random_keys();
            scan_all();                             // 10..15 read as no key
        end
        end_test("random_patterns");

        clear_keys();
        key_event(4'd2, 3'd1, 1'b1);
        key_event(4'd7, 3'd6, 1'b1);
        scan_col(4'd2);
        cpu_write(16'hE820, 8'h07);                 // PIA2 port A
        cpu_write(16'hE840, 8'h07);                 // VIA
        cpu_write(16'hD810, 8'h07);                 // Outside the I/O page
        cpu_write(16'hE830, 8'h07);                 // PIA1 and PIA2 overlap
        cpu_write(16'hE850, 8'h07);                 // PIA1 and VIA overlap
        cpu_write(16'hE870, 8'h07);
        cpu_read(16'hE822, 1'b0, 8'h00, 1'b0);
        cpu_read(16'hE842, 1'b0, 8'h00, 1'b0);
        cpu_read(16'hD812, 1'b0, 8'h00, 1'b0);
        cpu_read(16'hE832, 1'b0, 8'h00, 1'b0);      // Contention gives no injection
        cpu_read(16'hE852, 1'b0, 8'h00, 1'b0);
        idle(3);
        read_port_b();                              // Still column 2
        end_test("ignored_cycles");

        key_event(4'd2, 3'd1, 1'b0);
        idle(3);
        read_port_b();
        key_event(4'd2, 3'd1, 1'b1);
        idle(3);
        read_port_b();
        clear_keys();
        idle(3);
        read_port_b();
        key_event(4'd12, 3'd0, 1'b1);               // No such column
        scan_all();
        end_test("release_and_clear");

        $display("checks passed %0d, failed %0d",
                 pass_cnt + mon_pass_cnt, fail_cnt + mon_fail_cnt);
        if (fail_cnt + mon_fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the cycle counts of the tests
    initial begin : watchdog
        int budget;
        budget = 2 + 5 + 11 + 3 * 161 + 23 + 96;    // Reset and then tests one to five
        #(budget * 30);                             // 20 ns per cycle plus half again
        $display("Timeout: the tests did not finish within %0d cycles plus margin", budget);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: verilog/io_address_decoder.sv
// I/O address decoder producing PIA1, PIA2 and VIA selects from the 6502 address bus
`timescale 1ns/1ps

module io_address_decoder (
    input  pet_io_pkg::addr_t   cpu_addr_i,
    output pet_io_pkg::io_sel_t io_sel_o
);

    logic page_hit;                     // Address lies in $E8xx
    logic pia1_bit;
    logic pia2_bit;
    logic via_bit;

    // Upper byte compare against the I/O page
    assign page_hit = cpu_addr_i[pet_io_pkg::ADDR_WIDTH-1 -: pet_io_pkg::IO_PAGE_WIDTH]
                      == pet_io_pkg::IO_PAGE;

    // Partial decoding, one address line per chip
    assign pia1_bit = cpu_addr_i[pet_io_pkg::IO_PIA1_BIT];
    assign pia2_bit = cpu_addr_i[pet_io_pkg::IO_PIA2_BIT];
    assign via_bit  = cpu_addr_i[pet_io_pkg::IO_VIA_BIT];

    always_comb begin
        io_sel_o = '0;

        // Selects only live inside the I/O page
        // e.g. $E830 raises both PIA selects, same as the real board
        io_sel_o.pia1_cs = page_hit & pia1_bit;
        io_sel_o.pia2_cs = page_hit & pia2_bit;
        io_sel_o.via_cs  = page_hit & via_bit;

        // A3..A0 feed the chips directly, PIAs use only the low two
        io_sel_o.rs      = cpu_addr_i[pet_io_pkg::VIA_RS_WIDTH-1:0];
    end

endmodule

// File: verilog/io_intercept.sv
// PIA1 keyboard interceptor latching the scanned column and answering port B reads from the buffer
`timescale 1ns/1ps

module io_intercept (
    input  logic                    wb_clock_i,
    input  logic                    rst_n_i,

    // CPU bus cycle
    input  logic                    cpu_be_i,       // One-cycle bus strobe
    input  logic                    cpu_we_i,
    input  pet_io_pkg::data_t       cpu_data_i,

    // From decoder and key buffer
    input  pet_io_pkg::io_sel_t     io_sel_i,
    input  pet_io_pkg::kbd_matrix_t kbd_matrix_i,

    // Read override
    output pet_io_pkg::data_t       cpu_data_o,
    output logic                    cpu_data_oe_o   // High one cycle when injecting a key
);

    pet_io_pkg::pia_rs_t   pia_rs;
    logic                  pia1_only;               // PIA1 selected with no overlap
    logic                  porta_wr;
    logic                  portb_rd;

    pet_io_pkg::kbd_col_t  col_latch_q;             // Column written by firmware to port A
    pet_io_pkg::kbd_col_t  selected_col_q;          // Pipeline stage 1
    pet_io_pkg::kbd_rows_t selected_rows_q;         // Pipeline stage 2, prepared row byte
    pet_io_pkg::kbd_rows_t col_rows;                // Lookup result for stage 2
    logic                  key_down;                // Some row in column pressed

    assign pia_rs = io_sel_i.rs[pet_io_pkg::PIA_RS_WIDTH-1:0];

    // Overlapping selects mean bus contention, leave those cycles alone
    assign pia1_only = io_sel_i.pia1_cs & ~io_sel_i.pia2_cs & ~io_sel_i.via_cs;

    assign porta_wr = cpu_be_i &  cpu_we_i & pia1_only & (pia_rs == pet_io_pkg::PIA_PORTA);
    assign portb_rd = cpu_be_i & ~cpu_we_i & pia1_only & (pia_rs == pet_io_pkg::PIA_PORTB);

    // Columns past the matrix read as no key
    always_comb begin
        if (selected_col_q < pet_io_pkg::kbd_col_t'(pet_io_pkg::KBD_COL_COUNT)) begin
            col_rows = kbd_matrix_i[selected_col_q];
        end else begin
            col_rows = pet_io_pkg::KBD_ROWS_NONE;
        end
    end

    assign key_down = selected_rows_q != pet_io_pkg::KBD_ROWS_NONE;

    // Control and pipeline state
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            col_latch_q     <= '0;
            selected_col_q  <= '0;
            selected_rows_q <= pet_io_pkg::KBD_ROWS_NONE;
            cpu_data_oe_o   <= 1'b0;
        end else begin
            cpu_data_oe_o <= 1'b0;                  // Pulse only

            if (cpu_be_i) begin
                if (porta_wr) begin
                    col_latch_q <= cpu_data_i[pet_io_pkg::PIA1_PORTA_KEY_D_OUT:
                                              pet_io_pkg::PIA1_PORTA_KEY_A_OUT];
                end
                if (portb_rd) begin
                    cpu_data_oe_o <= key_down;      // Let the real PIA drive when nothing pressed
                end
            end else begin
                // Idle cycles refresh the lookup, two stages to ease timing
                selected_col_q  <= col_latch_q;
                selected_rows_q <= col_rows;
            end
        end
    end

    // Read data register holds its last value
    always_ff @(posedge wb_clock_i) begin
        if (portb_rd) begin
            cpu_data_o <= selected_rows_q;          // Row byte, 0 bits = pressed keys
        end
    end

endmodule

// File: verilog/pet_io_pkg.sv
// PET I/O keyboard injection package with widths, address map, register indices and bus structs
package pet_io_pkg;

    // CPU bus
    localparam int DATA_WIDTH   = 8;                    // 6502 data bus
    localparam int ADDR_WIDTH   = 16;                   // 6502 address bus
    localparam int VIA_RS_WIDTH = 4;                    // VIA decodes A3..A0
    localparam int PIA_RS_WIDTH = 2;                    // PIA decodes A1..A0 only

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [VIA_RS_WIDTH-1:0] rs_t;
    typedef logic [PIA_RS_WIDTH-1:0] pia_rs_t;

    // Keyboard matrix geometry, PET scans 10 columns of 8 rows
    localparam int KBD_COL_COUNT = 10;
    localparam int KBD_ROW_COUNT = 8;
    localparam int KBD_COL_WIDTH = $clog2(KBD_COL_COUNT);  // 4 bits, covers 0..15
    localparam int KBD_ROW_WIDTH = $clog2(KBD_ROW_COUNT);  // 3 bits

    typedef logic [KBD_COL_WIDTH-1:0] kbd_col_t;
    typedef logic [KBD_ROW_WIDTH-1:0] kbd_row_t;
    typedef logic [KBD_ROW_COUNT-1:0] kbd_rows_t;          // One column of rows, 0 = pressed

    // Whole key state, indexed [col][row], active low
    typedef kbd_rows_t [KBD_COL_COUNT-1:0] kbd_matrix_t;

    localparam kbd_rows_t KBD_ROWS_NONE = '1;              // No key down in column

    // I/O page decoding
    localparam int IO_PAGE_WIDTH = 8;
    localparam logic [IO_PAGE_WIDTH-1:0] IO_PAGE = 8'hE8;  // $E8xx

    // Partial decode, any of these may overlap
    localparam int IO_PIA1_BIT = 4;                        // A4 -> PIA1
    localparam int IO_PIA2_BIT = 5;                        // A5 -> PIA2
    localparam int IO_VIA_BIT  = 6;                        // A6 -> VIA

    // PIA data register indices
    localparam pia_rs_t PIA_PORTA = 2'd0;
    localparam pia_rs_t PIA_PORTB = 2'd2;

    // PIA1 port A bits that carry the scanned keyboard column
    localparam int PIA1_PORTA_KEY_A_OUT = 0;
    localparam int PIA1_PORTA_KEY_D_OUT = 3;

    // Chip selects plus register select, 7 bits
    typedef struct packed {
        logic pia1_cs;
        logic pia2_cs;
        logic via_cs;
        rs_t  rs;
    } io_sel_t;

    // Host key event, 8 bits
    typedef struct packed {
        kbd_col_t col;
        kbd_row_t row;
        logic     pressed;                                 // 1 = key went down
    } kbd_event_t;

endpackage

// File: verilog/pet_io_top.sv
// PET I/O keyboard injection top level tying decoder, key buffer and interceptor together
`timescale 1ns/1ps

module pet_io_top (
    input  logic                   wb_clock_i,
    input  logic                   rst_n_i,

    // 6502 side
    input  logic                   cpu_be_i,        // Bus cycle strobe
    input  logic                   cpu_we_i,
    input  pet_io_pkg::addr_t      cpu_addr_i,
    input  pet_io_pkg::data_t      cpu_data_i,
    output pet_io_pkg::data_t      cpu_data_o,
    output logic                   cpu_data_oe_o,   // Override enable for PIA1 port B reads

    // USB host side
    input  logic                   kbd_we_i,
    input  pet_io_pkg::kbd_event_t kbd_event_i,
    input  logic                   kbd_clear_i
);

    pet_io_pkg::io_sel_t     io_sel;                // Decoded chip and register selects
    pet_io_pkg::kbd_matrix_t kbd_matrix;            // Buffered key state

    // Address to chip selects
    io_address_decoder u_decoder (
        .cpu_addr_i (cpu_addr_i),
        .io_sel_o   (io_sel)
    );

    // Key state from the USB host
    usb_kbd_matrix u_matrix (
        .wb_clock_i   (wb_clock_i),
        .rst_n_i      (rst_n_i),
        .kbd_we_i     (kbd_we_i),
        .kbd_event_i  (kbd_event_i),
        .kbd_clear_i  (kbd_clear_i),
        .kbd_matrix_o (kbd_matrix)
    );

    // Column tracking and port B injection
    io_intercept u_intercept (
        .wb_clock_i    (wb_clock_i),
        .rst_n_i       (rst_n_i),
        .cpu_be_i      (cpu_be_i),
        .cpu_we_i      (cpu_we_i),
        .cpu_data_i    (cpu_data_i),
        .io_sel_i      (io_sel),
        .kbd_matrix_i  (kbd_matrix),
        .cpu_data_o    (cpu_data_o),
        .cpu_data_oe_o (cpu_data_oe_o)
    );

endmodule

// File: verilog/usb_kbd_matrix.sv
// USB keyboard matrix buffer holding active-low key state, updated by host key strobes
`timescale 1ns/1ps

module usb_kbd_matrix (
    input  logic                    wb_clock_i,
    input  logic                    rst_n_i,

    // Host side
    input  logic                    kbd_we_i,       // One-cycle key strobe
    input  pet_io_pkg::kbd_event_t  kbd_event_i,
    input  logic                    kbd_clear_i,    // Release every key

    output pet_io_pkg::kbd_matrix_t kbd_matrix_o
);

    pet_io_pkg::kbd_matrix_t matrix_q;
    logic                    col_valid;             // Event names one of the 10 real columns
    logic                    key_level;             // Bit value to store, 0 = pressed

    // Columns 10..15 have no storage
    assign col_valid = kbd_event_i.col < pet_io_pkg::kbd_col_t'(pet_io_pkg::KBD_COL_COUNT);

    // Active low in the matrix
    assign key_level = ~kbd_event_i.pressed;

    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            matrix_q <= '1;                         // All keys up
        end else if (kbd_clear_i) begin
            // Clear wins over a strobe in the same cycle
            matrix_q <= '1;
        end else if (kbd_we_i && col_valid) begin
            matrix_q[kbd_event_i.col][kbd_event_i.row] <= key_level;
        end
    end

    // Registered level, visible one edge after the strobe
    assign kbd_matrix_o = matrix_q;

endmodule
